// File: design/exIsaPkg.sv
// Execute ISA package: ALU opcodes, branch conditions and operand select encodings
package exIsaPkg;

   // ==============================
   // ALU operations
   // ==============================
   typedef enum logic [3:0] {
      ADD   = 4'h0,
      SUB   = 4'h1,
      AND   = 4'h2,
      OR    = 4'h3,
      XOR   = 4'h4,
      ANDN  = 4'h5,
      SLL   = 4'h6,
      SRL   = 4'h7,
      ROL   = 4'h8,
      ROR   = 4'h9,
      SEQ   = 4'hA,
      SLT   = 4'hB,
      SLE   = 4'hC,
      SCO   = 4'hD,
      PASSA = 4'hE,
      PASSB = 4'hF
   } aluOpE;

   // Conditions test the flags of rs (PASSA)
   typedef enum logic [2:0] {
      NONE = 3'd0,
      BEQZ = 3'd1,
      BNEZ = 3'd2,
      BLTZ = 3'd3,
      BGEZ = 3'd4
   } brCondE;

   // ==============================
   // Operand and offset selects
   // ==============================
   typedef enum logic [1:0] {
      RT   = 2'd0,
      IMM5 = 2'd1,
      IMM8 = 2'd2,
      ZERO = 2'd3
   } bSrcE;

   typedef enum logic [1:0] {
      REG   = 2'd0,
      EXMEM = 2'd1,
      MEMWB = 2'd2
   } fwdSelE;

   typedef enum logic {
      OFF8  = 1'b0,
      OFF11 = 1'b1
   } offSelE;

endpackage

// File: design/exPipePkg.sv
// Pipeline package: structs passed from decode into execute and on to memory
package exPipePkg;

   localparam int wordW = 16;

   // Decoded control, 13 bits
   typedef struct packed {
      exIsaPkg::aluOpE  aluOp;
      exIsaPkg::bSrcE   bSrc;
      exIsaPkg::brCondE brCond;
      exIsaPkg::offSelE offSel;
      logic             aluJmp;
      logic             halt;
      logic             nop;
   } exCtrlS;

   // Immediates arrive already extended by decode
   typedef struct packed {
      logic [wordW-1:0] pc;
      logic [wordW-1:0] rsData;
      logic [wordW-1:0] rtData;
      logic [wordW-1:0] imm5;
      logic [wordW-1:0] imm8;
      logic [wordW-1:0] sImm8;
      logic [wordW-1:0] sImm11;
      exCtrlS           ctrl;
   } idExS;

   typedef struct packed {
      logic [wordW-1:0] exMemData;
      logic [wordW-1:0] memWbData;
      exIsaPkg::fwdSelE aSel;
      exIsaPkg::fwdSelE bSel;
   } fwdS;

   typedef struct packed {
      logic             valid;
      logic [wordW-1:0] aluOut;
      logic [wordW-1:0] storeData;
      logic [wordW-1:0] pcNext;
      logic             brTaken;
      logic             halt;
   } exMemS;

endpackage

// File: design/claAdder.sv
// Carry-lookahead adder, 4-bit groups with a lookahead carry unit across groups
`timescale 1ns/1ps

module claAdder #(
   parameter int dataWidth = 16
) (
   input  logic [dataWidth-1:0] a,
   input  logic [dataWidth-1:0] b,
   input  logic                 cIn,
   output logic [dataWidth-1:0] sum,
   output logic                 cOut
);

   localparam int numGroups = dataWidth / 4;

   logic [dataWidth-1:0] p;
   logic [dataWidth-1:0] g;
   logic [dataWidth-1:0] c;
   logic [numGroups-1:0] grpP;
   logic [numGroups-1:0] grpG;
   logic [numGroups:0]   grpC;

   assign p = a ^ b;
   assign g = a & b;

   // ==============================
   // Per-group terms and bit carries
   // ==============================
   for (genvar k = 0; k < numGroups; k++) begin : gGroup
      localparam int base = 4 * k;

      assign grpP[k] = &p[base +: 4];
      assign grpG[k] = g[base+3]
                     | (p[base+3] & g[base+2])
                     | (p[base+3] & p[base+2] & g[base+1])
                     | (p[base+3] & p[base+2] & p[base+1] & g[base]);

      assign c[base]   = grpC[k];
      assign c[base+1] = g[base] | (p[base] & grpC[k]);
      assign c[base+2] = g[base+1] | (p[base+1] & g[base])
                       | (p[base+1] & p[base] & grpC[k]);
      assign c[base+3] = g[base+2] | (p[base+2] & g[base+1])
                       | (p[base+2] & p[base+1] & g[base])
                       | (p[base+2] & p[base+1] & p[base] & grpC[k]);
   end

   // ==============================
   // Group carries, two-level form
   // ==============================
   always_comb begin
      logic term;
      term = 1'b0;
      for (int k = 0; k <= numGroups; k++) begin
         grpC[k] = 1'b0;
         for (int j = 0; j <= k; j++) begin
            // Carry source j, propagated through groups j..k-1
            term = (j == 0) ? cIn : grpG[j-1];
            for (int m = j; m < k; m++) begin
               term = term & grpP[m];
            end
            grpC[k] = grpC[k] | term;
         end
      end
   end

   assign sum  = p ^ c;
   assign cOut = grpC[numGroups];

endmodule

// File: design/alu.sv
// ALU: sixteen operations on two operands, with zero, sign, overflow and carry flags
`timescale 1ns/1ps

module alu #(
   parameter int dataWidth = 16
) (
   input  logic [dataWidth-1:0] inA,
   input  logic [dataWidth-1:0] inB,
   input  exIsaPkg::aluOpE      aluOp,
   output logic [dataWidth-1:0] result,
   output logic                 zf,
   output logic                 sf,
   output logic                 of,
   output logic                 cf
);

   import exIsaPkg::*;

   localparam int msb = dataWidth - 1;

   logic [dataWidth-1:0] addB;
   logic [dataWidth-1:0] sum;
   logic                 addCout;
   logic                 subMode;
   logic                 ovf;
   logic                 lessThan;
   logic [3:0]           shamt;

   // Compares reuse the subtractor
   assign subMode = (aluOp == SUB) || (aluOp == SEQ) || (aluOp == SLT) || (aluOp == SLE);
   assign addB    = subMode ? ~inB : inB;

   claAdder #(.dataWidth(dataWidth)) uAdder (
      .a    (inA),
      .b    (addB),
      .cIn  (subMode),
      .sum  (sum),
      .cOut (addCout)
   );

   // Same-sign inputs and a sign flip in the sum
   assign ovf      = (inA[msb] == addB[msb]) && (sum[msb] != inA[msb]);
   assign lessThan = sum[msb] ^ ovf;
   assign shamt    = inB[3:0];

   always_comb begin
      case (aluOp)
         ADD, SUB: result = sum;
         AND:      result = inA & inB;
         OR:       result = inA | inB;
         XOR:      result = inA ^ inB;
         ANDN:     result = inA & ~inB;
         SLL:      result = inA << shamt;
         SRL:      result = inA >> shamt;
         ROL:      result = (inA << shamt) | (inA >> (dataWidth - shamt));
         ROR:      result = (inA >> shamt) | (inA << (dataWidth - shamt));
         SEQ:      result = dataWidth'(sum == '0);
         SLT:      result = dataWidth'(lessThan);
         SLE:      result = dataWidth'(lessThan || (sum == '0));
         SCO:      result = dataWidth'(addCout);
         PASSA:    result = inA;
         PASSB:    result = inB;
         default:  result = '0;
      endcase
   end

   // ==============================
   // Flags
   // ==============================
   assign zf = (result == '0);
   assign sf = result[msb];
   assign of = ((aluOp == ADD) || (aluOp == SUB)) && ovf;
   assign cf = ((aluOp == ADD) || (aluOp == SUB) || (aluOp == SCO)) && addCout;

endmodule

// File: design/branchCond.sv
// Branch condition unit: decides branch taken from the condition code and rs flags
`timescale 1ns/1ps

module branchCond (
   input  exIsaPkg::brCondE brCond,
   input  logic             nop,
   input  logic             zf,
   input  logic             sf,
   output logic             taken
);

   import exIsaPkg::*;

   logic condMet;

   always_comb begin
      case (brCond)
         BEQZ:    condMet = zf;
         BNEZ:    condMet = !zf;
         BLTZ:    condMet = sf;
         BGEZ:    condMet = !sf;
         default: condMet = 1'b0;
      endcase
   end

   // Bubbles never redirect fetch
   assign taken = condMet && !nop;

endmodule

// File: design/executeStage.sv
// Execute stage: operand forwarding, ALU, branch target and next-PC selection
`timescale 1ns/1ps

module executeStage #(
   parameter int dataWidth = 16
) (
   input  exPipePkg::idExS      idEx,
   input  exPipePkg::fwdS       fwd,
   output exPipePkg::exMemS     exResult,
   output logic                 brTaken,
   output logic [dataWidth-1:0] pcNext
);

   import exIsaPkg::*;
   import exPipePkg::*;

   logic [dataWidth-1:0] opA;
   logic [dataWidth-1:0] rtFwd;
   logic [dataWidth-1:0] opB;
   logic [dataWidth-1:0] aluOut;
   logic [dataWidth-1:0] offset;
   logic [dataWidth-1:0] target;
   logic                 zf;
   logic                 sf;
   logic                 taken;

   function automatic logic [dataWidth-1:0] fwdMux(
      input fwdSelE               sel,
      input logic [dataWidth-1:0] regVal,
      input logic [dataWidth-1:0] exMemVal,
      input logic [dataWidth-1:0] memWbVal
   );
      case (sel)
         EXMEM:   return exMemVal;
         MEMWB:   return memWbVal;
         default: return regVal;
      endcase
   endfunction

   // ==============================
   // Operand selection
   // ==============================
   assign opA   = fwdMux(fwd.aSel, idEx.rsData, fwd.exMemData, fwd.memWbData);
   assign rtFwd = fwdMux(fwd.bSel, idEx.rtData, fwd.exMemData, fwd.memWbData);

   always_comb begin
      case (idEx.ctrl.bSrc)
         RT:      opB = rtFwd;
         IMM5:    opB = idEx.imm5;
         IMM8:    opB = idEx.imm8;
         default: opB = '0;
      endcase
   end

   alu #(.dataWidth(dataWidth)) uAlu (
      .inA    (opA),
      .inB    (opB),
      .aluOp  (idEx.ctrl.aluOp),
      .result (aluOut),
      .zf     (zf),
      .sf     (sf),
      .of     (),
      .cf     ()
   );

   branchCond uBrCond (
      .brCond (idEx.ctrl.brCond),
      .nop    (idEx.ctrl.nop),
      .zf     (zf),
      .sf     (sf),
      .taken  (taken)
   );

   // ==============================
   // Branch target and next PC
   // ==============================
   assign offset = (idEx.ctrl.offSel == OFF8) ? idEx.sImm8 : idEx.sImm11;

   claAdder #(.dataWidth(dataWidth)) uTargetAdder (
      .a    (idEx.pc),
      .b    (offset),
      .cIn  (1'b0),
      .sum  (target),
      .cOut ()
   );

   // Halt keeps the PC where it is
   assign brTaken = taken && !idEx.ctrl.halt;
   assign pcNext  = idEx.ctrl.aluJmp ? aluOut : (brTaken ? target : idEx.pc);

   assign exResult.valid     = !idEx.ctrl.nop;
   assign exResult.aluOut    = aluOut;
   assign exResult.storeData = rtFwd;
   assign exResult.pcNext    = pcNext;
   assign exResult.brTaken   = brTaken;
   assign exResult.halt      = idEx.ctrl.halt;

endmodule

// File: design/exMemReg.sv
// EX/MEM pipeline register: loads each cycle, holds under stall, clears on reset
`timescale 1ns/1ps

module exMemReg (
   input  logic             clk,
   input  logic             arstN,
   input  logic             stall,
   input  exPipePkg::exMemS exResult,
   output exPipePkg::exMemS exMem
);

   // Bubbles load like any other item, valid already low
   always_ff @(posedge clk or negedge arstN) begin
      if (!arstN) begin
         exMem <= '0;
      end else if (!stall) begin
         exMem <= exResult;
      end
   end

endmodule

// File: design/exTop.sv
// Execute top: execute stage feeding the EX/MEM pipeline register
`timescale 1ns/1ps

module exTop #(
   parameter int dataWidth = exPipePkg::wordW
) (
   input  logic                 clk,
   input  logic                 arstN,
   input  exPipePkg::idExS      idEx,
   input  exPipePkg::fwdS       fwd,
   input  logic                 stall,
   output exPipePkg::exMemS     exMem,
   output logic                 brTaken,
   output logic [dataWidth-1:0] pcNext
);

   import exPipePkg::*;

   exMemS exResult;

   executeStage #(.dataWidth(dataWidth)) uExecute (
      .idEx     (idEx),
      .fwd      (fwd),
      .exResult (exResult),
      .brTaken  (brTaken),
      .pcNext   (pcNext)
   );

   exMemReg uExMemReg (
      .clk      (clk),
      .arstN    (arstN),
      .stall    (stall),
      .exResult (exResult),
      .exMem    (exMem)
   );

endmodule

// File: dv/exTop_properties.sv
// EX/MEM assertions: hold under stall, no branch on bubbles, empty after reset
`timescale 1ns/1ps

module exTopProperties (
   input logic             clk,
   input logic             arstN,
   input logic             stall,
   input exPipePkg::idExS  idEx,
   input exPipePkg::exMemS exMem,
   input logic             brTaken
);

   int assertFails = 0;

   holdUnderStall: assert property (@(posedge clk) disable iff (!arstN)
      stall |=> $stable(exMem))
      else begin
         assertFails++;
         $error("exMem changed across an edge with stall high");
      end

   noBranchOnBubble: assert property (@(posedge clk) disable iff (!arstN)
      idEx.ctrl.nop |-> !brTaken)
      else begin
         assertFails++;
         $error("brTaken high for a bubble");
      end

   // First edge after release still shows the cleared register
   emptyAfterReset: assert property (@(posedge clk)
      $rose(arstN) |-> !exMem.valid)
      else begin
         assertFails++;
         $error("exMem.valid high right after reset release");
      end

endmodule

bind exTop exTopProperties uProps (
   .clk     (clk),
   .arstN   (arstN),
   .stall   (stall),
   .idEx    (idEx),
   .exMem   (exMem),
   .brTaken (brTaken)
);

// File: dv/exChecker.sv
// Execute checker: reference model of the stage and cycle-by-cycle comparison
`timescale 1ns/1ps

module exChecker (
   input  logic                        clk,
   input  logic                        arstN,
   input  exPipePkg::idExS             idEx,
   input  exPipePkg::fwdS              fwd,
   input  logic                        stall,
   input  exPipePkg::exMemS            exMem,
   input  logic                        brTaken,
   input  logic [exPipePkg::wordW-1:0] pcNext,
   output int                          errCount,
   output int                          checkCount
);

   import exIsaPkg::*;
   import exPipePkg::*;

   // Expected register contents and the current cycle's result
   exMemS expReg;
   exMemS expNow;

   // ==============================
   // Reference model
   // ==============================
   function automatic logic [wordW-1:0] aluModel(input aluOpE op, input logic [wordW-1:0] a,
                                                 input logic [wordW-1:0] b);
      logic [2*wordW-1:0] rolW;
      logic [2*wordW-1:0] rorW;
      logic [wordW:0]     wideSum;
      int                 sh;
      sh      = b[3:0];
      rolW    = {a, a} << sh;
      rorW    = {a, a} >> sh;
      wideSum = {1'b0, a} + {1'b0, b};
      case (op)
         ADD:     return a + b;
         SUB:     return a - b;
         AND:     return a & b;
         OR:      return a | b;
         XOR:     return a ^ b;
         ANDN:    return a & ~b;
         SLL:     return a << sh;
         SRL:     return a >> sh;
         ROL:     return rolW[2*wordW-1:wordW];
         ROR:     return rorW[wordW-1:0];
         SEQ:     return wordW'(a == b);
         SLT:     return wordW'($signed(a) < $signed(b));
         SLE:     return wordW'($signed(a) <= $signed(b));
         SCO:     return wordW'(wideSum[wordW]);
         PASSA:   return a;
         PASSB:   return b;
         default: return '0;
      endcase
   endfunction

   function automatic logic [wordW-1:0] selectSource(input fwdSelE sel,
                                                     input logic [wordW-1:0] regVal,
                                                     input fwdS f);
      case (sel)
         EXMEM:   return f.exMemData;
         MEMWB:   return f.memWbData;
         default: return regVal;
      endcase
   endfunction

   function automatic exMemS executeModel(input idExS ins, input fwdS f);
      exMemS            res;
      logic [wordW-1:0] a;
      logic [wordW-1:0] rt;
      logic [wordW-1:0] b;
      logic [wordW-1:0] off;
      logic             cond;
      a  = selectSource(f.aSel, ins.rsData, f);
      rt = selectSource(f.bSel, ins.rtData, f);
      case (ins.ctrl.bSrc)
         RT:      b = rt;
         IMM5:    b = ins.imm5;
         IMM8:    b = ins.imm8;
         default: b = '0;
      endcase
      res.aluOut = aluModel(ins.ctrl.aluOp, a, b);
      case (ins.ctrl.brCond)
         BEQZ:    cond = (res.aluOut == '0);
         BNEZ:    cond = (res.aluOut != '0);
         BLTZ:    cond = res.aluOut[wordW-1];
         BGEZ:    cond = !res.aluOut[wordW-1];
         default: cond = 1'b0;
      endcase
      off           = (ins.ctrl.offSel == OFF11) ? ins.sImm11 : ins.sImm8;
      res.valid     = !ins.ctrl.nop;
      res.storeData = rt;
      res.brTaken   = cond && !ins.ctrl.nop && !ins.ctrl.halt;
      res.halt      = ins.ctrl.halt;
      if (ins.ctrl.aluJmp) begin
         res.pcNext = res.aluOut;
      end else if (res.brTaken) begin
         res.pcNext = ins.pc + off;
      end else begin
         res.pcNext = ins.pc;
      end
      return res;
   endfunction

   // ==============================
   // Comparison
   // ==============================
   task automatic checkValue(input string name, input logic [wordW-1:0] expected,
                             input logic [wordW-1:0] actual);
      checkCount++;
      if (actual !== expected) begin
         errCount++;
         $display("error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task automatic verifyExMem();
      checkValue("exMem.valid", wordW'(expReg.valid), wordW'(exMem.valid));
      checkValue("exMem.aluOut", expReg.aluOut, exMem.aluOut);
      checkValue("exMem.storeData", expReg.storeData, exMem.storeData);
      checkValue("exMem.pcNext", expReg.pcNext, exMem.pcNext);
      checkValue("exMem.brTaken", wordW'(expReg.brTaken), wordW'(exMem.brTaken));
      checkValue("exMem.halt", wordW'(expReg.halt), wordW'(exMem.halt));
   endtask

   initial begin
      errCount   = 0;
      checkCount = 0;
      expReg     = '0;
   end

   // Inputs change on the rising edge, so the falling edge sees them settled
   always @(negedge clk) begin
      if (!arstN) begin
         expReg = '0;
         verifyExMem();
      end else begin
         expNow = executeModel(idEx, fwd);
         checkValue("brTaken", wordW'(expNow.brTaken), wordW'(brTaken));
         checkValue("pcNext", expNow.pcNext, pcNext);
         verifyExMem();
         if (!stall) begin
            expReg = expNow;
         end
      end
   end

endmodule

// File: dv/exTb.sv
// Execute stage testbench: clock, reset, directed and random instruction stimulus
`timescale 1ns/1ps

module exTb;

   import exIsaPkg::*;
   import exPipePkg::*;

   localparam int clkPeriod = 10;
   localparam int aluTests  = 16 * 16;
   localparam int selTests  = 2 * 3 * 3 * 4;
   localparam int brTests   = 5 * 3 * 2 * 2;
   localparam int jmpTests  = 24;
   localparam int pipeTests = 300;
   localparam int numTests  = aluTests + selTests + brTests + jmpTests + pipeTests + 20;
   localparam int marginNs  = 500;

   logic             clk = 1'b0;
   logic             arstN;
   idExS             idEx;
   fwdS              fwd;
   logic             stall;
   exMemS            exMem;
   logic             brTaken;
   logic [wordW-1:0] pcNext;
   int               errCount;
   int               checkCount;
   integer           seed = 32'hfc7b;

   exTop #(.dataWidth(wordW)) u_dut (
      .clk     (clk),
      .arstN   (arstN),
      .idEx    (idEx),
      .fwd     (fwd),
      .stall   (stall),
      .exMem   (exMem),
      .brTaken (brTaken),
      .pcNext  (pcNext)
   );

   exChecker uChecker (
      .clk        (clk),
      .arstN      (arstN),
      .idEx       (idEx),
      .fwd        (fwd),
      .stall      (stall),
      .exMem      (exMem),
      .brTaken    (brTaken),
      .pcNext     (pcNext),
      .errCount   (errCount),
      .checkCount (checkCount)
   );

   initial begin
      forever #(clkPeriod / 2) clk = ~clk;
   end

   initial begin
      #(numTests * clkPeriod + marginNs);
      $display("Timeout: run still going after %0d ns", numTests * clkPeriod + marginNs);
      $display("Test failed");
      $finish;
   end

   // Edge values show up about three times in four
   function automatic logic [wordW-1:0] pickOperand();
      logic [31:0] r;
      r = $random(seed);
      case (r[17:16])
         2'd0:    return 16'h0000;
         2'd1:    return 16'h8000;
         2'd2:    return 16'hFFFF;
         default: return r[15:0];
      endcase
   endfunction

   function automatic idExS makeInstr();
      idExS        ins;
      logic [31:0] r;
      r = $random(seed);
      ins.pc     = r[15:0];
      ins.imm5   = {11'b0, r[20:16]};
      ins.imm8   = {8'b0, r[28:21]};
      r = $random(seed);
      ins.sImm8  = {{8{r[7]}}, r[7:0]};
      ins.sImm11 = {{5{r[18]}}, r[18:8]};
      ins.rsData = pickOperand();
      ins.rtData = pickOperand();
      r = $random(seed);
      ins.ctrl.aluOp  = aluOpE'(r[3:0]);
      ins.ctrl.bSrc   = bSrcE'(r[5:4]);
      ins.ctrl.brCond = NONE;
      ins.ctrl.offSel = offSelE'(r[6]);
      ins.ctrl.aluJmp = 1'b0;
      ins.ctrl.halt   = 1'b0;
      ins.ctrl.nop    = 1'b0;
      return ins;
   endfunction

   function automatic fwdS mixedFwd();
      fwdS         f;
      logic [31:0] r;
      r = $random(seed);
      f.exMemData = pickOperand();
      f.memWbData = pickOperand();
      f.aSel      = fwdSelE'(2'(r[1:0] % 3));
      f.bSel      = fwdSelE'(2'(r[3:2] % 3));
      return f;
   endfunction

   function automatic fwdS registerFwd();
      fwdS f;
      f      = mixedFwd();
      f.aSel = REG;
      f.bSel = REG;
      return f;
   endfunction

   task automatic applyCycle(input idExS ins, input fwdS f, input logic stallVal);
      @(posedge clk);
      idEx  <= ins;
      fwd   <= f;
      stall <= stallVal;
   endtask

   initial begin
      idExS        ins;
      fwdS         fw;
      logic [31:0] r;
      arstN         = 1'b0;
      stall         = 1'b0;
      idEx          = '0;
      idEx.ctrl.nop = 1'b1;
      fwd           = '0;
      repeat (2) @(posedge clk);
      arstN <= 1'b1;

      // ==============================
      // ALU operations
      // ==============================
      for (int op = 0; op < 16; op++) begin
         for (int k = 0; k < 16; k++) begin
            ins = makeInstr();
            ins.ctrl.aluOp = aluOpE'(4'(op));
            ins.ctrl.bSrc  = RT;
            applyCycle(ins, registerFwd(), 1'b0);
         end
      end

      // Distinct value on every source
      for (int pass = 0; pass < 2; pass++) begin
         for (int a = 0; a < 3; a++) begin
            for (int b = 0; b < 3; b++) begin
               for (int s = 0; s < 4; s++) begin
                  ins = makeInstr();
                  ins.rsData     = 16'h1100 + 16'(pass);
                  ins.rtData     = 16'h2200 + 16'(pass);
                  ins.imm5       = 16'h0005 + 16'(pass);
                  ins.imm8       = 16'h0080 + 16'(pass);
                  ins.ctrl.aluOp = (pass == 0) ? ADD : XOR;
                  ins.ctrl.bSrc  = bSrcE'(2'(s));
                  fw.exMemData   = 16'h3300 + 16'(pass);
                  fw.memWbData   = 16'h4400 + 16'(pass);
                  fw.aSel        = fwdSelE'(2'(a));
                  fw.bSel        = fwdSelE'(2'(b));
                  applyCycle(ins, fw, 1'b0);
               end
            end
         end
      end

      // ==============================
      // Branches and register jumps
      // ==============================
      for (int c = 0; c < 5; c++) begin
         for (int v = 0; v < 3; v++) begin
            for (int o = 0; o < 2; o++) begin
               for (int h = 0; h < 2; h++) begin
                  ins = makeInstr();
                  r = $random(seed);
                  ins.ctrl.aluOp  = PASSA;
                  ins.ctrl.brCond = brCondE'(3'(c));
                  ins.ctrl.offSel = offSelE'(1'(o));
                  ins.ctrl.halt   = 1'(h);
                  case (v)
                     0:       ins.rsData = 16'h0000;
                     1:       ins.rsData = {1'b1, r[14:0]};
                     default: ins.rsData = {1'b0, r[14:0]} | 16'h0001;
                  endcase
                  applyCycle(ins, registerFwd(), 1'b0);
               end
            end
         end
      end

      for (int k = 0; k < jmpTests; k++) begin
         ins = makeInstr();
         r = $random(seed);
         ins.ctrl.aluJmp = 1'b1;
         ins.ctrl.brCond = brCondE'(3'(r[7:0] % 5));
         ins.ctrl.halt   = r[8];
         applyCycle(ins, mixedFwd(), 1'b0);
      end

      // ==============================
      // Stalls, bubbles and a second reset
      // ==============================
      for (int k = 0; k < pipeTests; k++) begin
         ins = makeInstr();
         r = $random(seed);
         ins.ctrl.brCond = brCondE'(3'(r[7:0] % 5));
         ins.ctrl.aluJmp = (r[11:8] == 4'd0);
         ins.ctrl.halt   = (r[15:12] == 4'd0);
         ins.ctrl.nop    = (r[18:16] < 3'd2);
         applyCycle(ins, mixedFwd(), r[23:20] < 4'd5);
      end

      @(posedge clk);
      arstN <= 1'b0;
      stall <= 1'b0;
      repeat (2) @(posedge clk);
      arstN <= 1'b1;
      for (int k = 0; k < 8; k++) begin
         applyCycle(makeInstr(), mixedFwd(), 1'b0);
      end
      repeat (3) @(posedge clk);

      $display("Checks: %0d, value errors: %0d, assertion failures: %0d",
               checkCount, errCount, u_dut.uProps.assertFails);
      if (errCount == 0 && u_dut.uProps.assertFails == 0) begin
         $display("Test passed");
      end else begin
         $display("Test failed");
      end
      $finish;
   end

endmodule

// File: tb.f
design/exIsaPkg.sv
design/exPipePkg.sv
design/claAdder.sv
design/alu.sv
design/branchCond.sv
design/executeStage.sv
design/exMemReg.sv
design/exTop.sv
dv/exTop_properties.sv
dv/exChecker.sv
dv/exTb.sv

// File: Bender.yml
package:
  name: ex_stage

sources:
  - files:
      - design/exIsaPkg.sv
      - design/exPipePkg.sv
      - design/claAdder.sv
      - design/alu.sv
      - design/branchCond.sv
      - design/executeStage.sv
      - design/exMemReg.sv
      - design/exTop.sv
  - target: test
    files:
      - dv/exTop_properties.sv
      - dv/exChecker.sv
      - dv/exTb.sv
